//--- axi_pkg.sv
package axi_pkg;

    // only the two codes this bus ever returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // address beat, same layout on ar and aw
    typedef struct packed {
        logic [31:0] addr;
        // 0 byte, 1 halfword, 2 word
        logic [2:0]  size;
    } axi_addr_t;

    // write data beat
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axi_w_t;

    // read data beat
    typedef struct packed {
        logic [31:0] data;
        axi_resp_e   resp;
    } axi_r_t;

    // write response beat
    typedef struct packed {
        axi_resp_e resp;
    } axi_b_t;

endpackage

//--- lsu_pkg.sv
package lsu_pkg;

    // memory opcodes, loads first
    typedef enum logic [2:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW
    } lsu_op_e;

    // one access from the core
    typedef struct packed {
        lsu_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } lsu_req_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        AR_WAIT,
        AR,
        R,
        W,
        B
    } lsu_state_e;

    // pacing gaps on the read path
    localparam int ISSUE_GAP  = 3;
    localparam int RREADY_GAP = 2;

    // memory slave depth in words
    localparam int MEM_WORDS = 256;

endpackage

//--- gap_timer.sv
`timescale 1ns/100ps

module gap_timer (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic [2:0] load,
    output logic       expired
);

    logic [2:0] count;

    // start always wins over a running count
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= 3'd0;
        end else if (start) begin
            count <= load;
        end else if (count != 3'd0) begin
            count <= count - 3'd1;
        end
    end

    // one-cycle pulse on the last count
    assign expired = (count == 3'd1);

    // a zero load would never expire
    a_load_nonzero: assert property (@(posedge clk) disable iff (rst)
        start |-> load != 3'd0);

endmodule

//--- load_align.sv
`timescale 1ns/100ps

module load_align (
    input  logic             clk,
    input  lsu_pkg::lsu_op_e op,
    input  logic [1:0]       byte_off,
    input  logic [31:0]      word,
    output logic [31:0]      value
);
    import lsu_pkg::*;

    logic [31:0] shifted;

    // bring addressed lane down to bit 0
    assign shifted = word >> {byte_off, 3'b000};

    always_comb begin
        case (op)
            LB:      value = {{24{shifted[7]}}, shifted[7:0]};
            LBU:     value = {24'h0, shifted[7:0]};
            LH:      value = {{16{shifted[15]}}, shifted[15:0]};
            LHU:     value = {16'h0, shifted[15:0]};
            LW:      value = shifted;
            // stores return nothing
            default: value = 32'h0;
        endcase
    end

    // no misaligned access reaches the bus
    a_half_even: assert property (@(posedge clk)
        (op inside {LH, LHU, SH}) |-> !byte_off[0]);
    a_word_zero: assert property (@(posedge clk)
        (op inside {LW, SW}) |-> byte_off == 2'b00);

endmodule

//--- store_align.sv
`timescale 1ns/100ps

module store_align (
    input  lsu_pkg::lsu_op_e op,
    input  logic [1:0]       addr_low,
    input  logic [31:0]      data,
    output axi_pkg::axi_w_t  w
);
    import lsu_pkg::*;

    always_comb begin
        // loads drive no lanes
        w = '0;
        case (op)
            SB: begin
                // byte copied to every lane
                w.data = {4{data[7:0]}};
                w.strb = 4'b0001 << addr_low;
            end
            SH: begin
                w.data = {2{data[15:0]}};
                w.strb = 4'b0011 << addr_low;
            end
            SW: begin
                w.data = data;
                w.strb = 4'b1111;
            end
            default: begin
                w = '0;
            end
        endcase
    end

endmodule

//--- axi_sram.sv
`timescale 1ns/100ps

module axi_sram (
    input  logic               clk,
    input  logic               rst,
    input  logic               arvalid,
    output logic               arready,
    input  axi_pkg::axi_addr_t ar,
    output logic               rvalid,
    input  logic               rready,
    output axi_pkg::axi_r_t    r,
    input  logic               awvalid,
    output logic               awready,
    input  axi_pkg::axi_addr_t aw,
    input  logic               wvalid,
    output logic               wready,
    input  axi_pkg::axi_w_t    w,
    output logic               bvalid,
    input  logic               bready,
    output axi_pkg::axi_b_t    b
);
    import axi_pkg::*;
    import lsu_pkg::*;

    logic [31:0] mem [MEM_WORDS];
    axi_addr_t   aw_q;
    axi_w_t      w_q;
    logic        aw_got;
    logic        w_got;
    axi_addr_t   aw_cur;
    axi_w_t      w_cur;
    logic [29:0] rd_idx;
    logic [29:0] wr_idx;
    logic        wr_fire;
    logic        idle;

    // accept anything while no response is pending
    assign idle    = !rvalid && !bvalid;
    assign arready = idle;
    assign awready = idle;
    assign wready  = idle;

    // aw and w may land in either order
    assign aw_cur  = aw_got ? aw_q : aw;
    assign w_cur   = w_got ? w_q : w;
    assign wr_fire = (aw_got || (awvalid && awready)) && (w_got || (wvalid && wready));

    assign rd_idx = ar.addr[31:2];
    assign wr_idx = aw_cur.addr[31:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= 32'h0;
            end
        end else begin
            // read, out of range gives zero data
            if (arvalid && arready) begin
                rvalid <= 1'b1;
                if (rd_idx < MEM_WORDS) begin
                    r <= '{data: mem[rd_idx[$clog2(MEM_WORDS)-1:0]], resp: OKAY};
                end else begin
                    r <= '{data: 32'h0, resp: SLVERR};
                end
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            // write once both halves are in
            if (wr_fire) begin
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                bvalid <= 1'b1;
                if (wr_idx < MEM_WORDS) begin
                    for (int j = 0; j < 4; j++) begin
                        if (w_cur.strb[j]) begin
                            mem[wr_idx[$clog2(MEM_WORDS)-1:0]][8*j +: 8] <= w_cur.data[8*j +: 8];
                        end
                    end
                    b.resp <= OKAY;
                end else begin
                    // dropped, no aliasing into low words
                    b.resp <= SLVERR;
                end
            end else begin
                if (awvalid && awready) begin
                    aw_got <= 1'b1;
                    aw_q   <= aw;
                end
                if (wvalid && wready) begin
                    w_got <= 1'b1;
                    w_q   <= w;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // one access at a time on the slave side
    a_one_resp: assert property (@(posedge clk) disable iff (rst) !(rvalid && bvalid));

endmodule

//--- lsu_ctrl.sv
`timescale 1ns/100ps

module lsu_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  lsu_pkg::lsu_req_t  req_info,
    output logic               done,
    output logic               busy,
    output logic               err,
    output logic               timer_start,
    output logic [2:0]         timer_load,
    input  logic               timer_done,
    output logic               arvalid,
    input  logic               arready,
    output axi_pkg::axi_addr_t ar,
    input  logic               rvalid,
    output logic               rready,
    input  axi_pkg::axi_r_t    r,
    output logic               awvalid,
    input  logic               awready,
    output axi_pkg::axi_addr_t aw,
    output logic               wvalid,
    input  logic               wready,
    input  axi_pkg::axi_w_t    w,
    output axi_pkg::axi_w_t    w_out,
    input  logic               bvalid,
    output logic               bready,
    input  axi_pkg::axi_b_t    b,
    output logic [31:0]        rdata_raw,
    output lsu_pkg::lsu_op_e   op,
    output logic [1:0]         byte_off
);
    import axi_pkg::*;
    import lsu_pkg::*;

    lsu_state_e  state;
    lsu_op_e     op_q;
    logic [31:0] addr_q;
    axi_w_t      w_q;
    logic [31:0] rdata_q;
    logic        aw_done;
    logic        w_done;
    logic        rready_q;
    logic [2:0]  size;
    logic        aw_hs;
    logic        w_hs;
    logic        req_store;

    assign req_store = req_info.op inside {SB, SH, SW};

    // access size from the held opcode
    always_comb begin
        case (op_q)
            LB, LBU, SB: size = 3'd0;
            LH, LHU, SH: size = 3'd1;
            default:     size = 3'd2;
        endcase
    end

    assign ar = '{addr: addr_q, size: size};
    assign aw = ar;

    // valids come straight off state, so they stay put
    assign arvalid = (state == AR);
    assign awvalid = (state == W) && !aw_done;
    assign wvalid  = (state == W) && !w_done;
    assign bready  = (state == B);
    // rready goes up with the timer pulse and then holds
    assign rready  = (state == R) && (rready_q || timer_done);
    assign busy    = (state != IDLE);

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;

    // issue gap from req, ready gap from the ar handshake
    assign timer_start = ((state == IDLE) && req && !req_store) || (arvalid && arready);
    assign timer_load  = (state == AR) ? 3'(RREADY_GAP) : 3'(ISSUE_GAP);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            op_q     <= LB;
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
            rready_q <= 1'b0;
            done     <= 1'b0;
            err      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (req) begin
                        op_q  <= req_info.op;
                        state <= req_store ? W : AR_WAIT;
                    end
                end
                AR_WAIT: begin
                    if (timer_done) begin
                        state <= AR;
                    end
                end
                AR: begin
                    if (arready) begin
                        state <= R;
                    end
                end
                R: begin
                    if (rvalid && rready) begin
                        rready_q <= 1'b0;
                        done     <= 1'b1;
                        err      <= (r.resp == SLVERR);
                        state    <= IDLE;
                    end else if (timer_done) begin
                        rready_q <= 1'b1;
                    end
                end
                W: begin
                    // address and data tracked on their own
                    if (aw_hs) begin
                        aw_done <= 1'b1;
                    end
                    if (w_hs) begin
                        w_done <= 1'b1;
                    end
                    if ((aw_done || aw_hs) && (w_done || w_hs)) begin
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        state   <= B;
                    end
                end
                B: begin
                    if (bvalid) begin
                        done  <= 1'b1;
                        err   <= (b.resp == SLVERR);
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // request payload and read word
    always_ff @(posedge clk) begin
        if ((state == IDLE) && req) begin
            addr_q <= req_info.addr;
            w_q    <= w;
        end
        if (rvalid && rready) begin
            rdata_q <= r.data;
        end
    end

    assign w_out     = w_q;
    assign rdata_raw = rdata_q;
    assign op        = op_q;
    assign byte_off  = addr_q[1:0];

    // core must wait for done
    a_no_req_busy: assert property (@(posedge clk) disable iff (rst) req |-> !busy);
    // ar held steady until taken
    a_ar_stable: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar));

endmodule

//--- lsu_top.sv
`timescale 1ns/100ps

module lsu_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  lsu_pkg::lsu_req_t req_info,
    output logic              done,
    output logic              busy,
    output logic              err,
    output logic [31:0]       rdata
);
    import axi_pkg::*;
    import lsu_pkg::*;

    logic        timer_start;
    logic [2:0]  timer_load;
    logic        timer_done;
    logic        arvalid;
    logic        arready;
    axi_addr_t   ar;
    logic        rvalid;
    logic        rready;
    axi_r_t      r;
    logic        awvalid;
    logic        awready;
    axi_addr_t   aw;
    logic        wvalid;
    logic        wready;
    // aligned from the raw request, then held in the controller
    axi_w_t      w_aligned;
    axi_w_t      w_bus;
    logic        bvalid;
    logic        bready;
    axi_b_t      b;
    logic [31:0] rdata_raw;
    lsu_op_e     op;
    logic [1:0]  byte_off;

    lsu_ctrl i_lsu_ctrl (
        .clk, .rst, .req, .req_info, .done, .busy, .err,
        .timer_start, .timer_load, .timer_done,
        .arvalid, .arready, .ar, .rvalid, .rready, .r,
        .awvalid, .awready, .aw, .wvalid, .wready,
        .w(w_aligned), .w_out(w_bus),
        .bvalid, .bready, .b,
        .rdata_raw, .op, .byte_off
    );

    gap_timer i_gap_timer (
        .clk, .rst,
        .start(timer_start), .load(timer_load), .expired(timer_done)
    );

    // load side works on the latched read word
    load_align i_load_align (
        .clk, .op, .byte_off, .word(rdata_raw), .value(rdata)
    );

    store_align i_store_align (
        .op(req_info.op), .addr_low(req_info.addr[1:0]),
        .data(req_info.wdata), .w(w_aligned)
    );

    axi_sram i_axi_sram (
        .clk, .rst,
        .arvalid, .arready, .ar, .rvalid, .rready, .r,
        .awvalid, .awready, .aw, .wvalid, .wready, .w(w_bus),
        .bvalid, .bready, .b
    );

endmodule

//--- tb_lsu.sv
`timescale 1ns/100ps

module tb_lsu;
    import lsu_pkg::*;

    localparam int          MAX_ROWS        = 64;
    localparam int          COLS            = 5;
    localparam int          RESET_CYCLES    = 4;
    localparam int          CYCLES_PER_TEST = 20;
    localparam int          LOAD_CYCLES     = ISSUE_GAP + RREADY_GAP + 2;
    localparam int          STORE_CYCLES    = 3;
    localparam logic [31:0] END_MARK        = 32'hf;

    logic        clk;
    logic        rst;
    logic        req;
    lsu_req_t    req_info;
    logic        done;
    logic        busy;
    logic        err;
    logic [31:0] rdata;

    // flat table of five words per access
    logic [31:0] rows [MAX_ROWS*COLS];
    int          n_tests;
    bit          loaded;
    int          errors;
    int          failed;

    lsu_top i_lsu_top (
        .clk, .rst, .req, .req_info, .done, .busy, .err, .rdata
    );

    // 8 ns period
    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic verify_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("ERR t=%0t %s exp=%0b got=%0b", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR t=%0t %s exp=%h got=%h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic match_count(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("ERR t=%0t %s exp=%0d got=%0d", $time, name, exp, got);
            errors++;
        end
    endtask

    // nothing on the bus may be up right after reset
    task automatic idle_after_reset();
        verify_bit("arvalid", i_lsu_top.arvalid, 1'b0);
        verify_bit("awvalid", i_lsu_top.awvalid, 1'b0);
        verify_bit("wvalid", i_lsu_top.wvalid, 1'b0);
        verify_bit("rready", i_lsu_top.rready, 1'b0);
        verify_bit("bready", i_lsu_top.bready, 1'b0);
        verify_bit("done", done, 1'b0);
        verify_bit("busy", busy, 1'b0);
    endtask

    // one access entered and left on a falling edge
    task automatic run_access(input int idx);
        lsu_op_e     cur_op;
        logic [31:0] addr;
        logic [31:0] exp_data;
        logic        exp_err;
        int          exp_cycles;
        int          cycles;
        bit          seen;
        int          errs_before;
        cur_op      = lsu_op_e'(rows[idx*COLS][2:0]);
        addr        = rows[idx*COLS+1];
        exp_data    = rows[idx*COLS+3];
        exp_err     = rows[idx*COLS+4][0];
        exp_cycles  = (cur_op inside {SB, SH, SW}) ? STORE_CYCLES : LOAD_CYCLES;
        errs_before = errors;
        req_info    = '{op: cur_op, addr: addr, wdata: rows[idx*COLS+2]};
        req         = 1'b1;
        cycles      = 0;
        seen        = 1'b0;
        // cycle 1 is the first falling edge after the req edge
        while (!seen && cycles < CYCLES_PER_TEST) begin
            @(negedge clk);
            req = 1'b0;
            cycles++;
            if (done) begin
                seen = 1'b1;
            end else begin
                verify_bit("busy", busy, 1'b1);
            end
        end
        assert (seen) else begin
            $display("test %0d: no done pulse within %0d cycles", idx, CYCLES_PER_TEST);
            errors++;
        end
        if (seen) begin
            compare_word("rdata", rdata, exp_data);
            verify_bit("err", err, exp_err);
            match_count("done latency", cycles, exp_cycles);
        end
        // single pulse and unit back in idle
        @(negedge clk);
        verify_bit("done", done, 1'b0);
        verify_bit("busy", busy, 1'b0);
        if (errors != errs_before) begin
            failed++;
        end
        $display("test %0d %s addr=%h: %s", idx, cur_op.name(), addr,
                 (errors == errs_before) ? "ok" : "FAILED");
    endtask

    // main sequence
    initial begin
        rst      = 1'b1;
        req      = 1'b0;
        req_info = '0;
        errors   = 0;
        failed   = 0;
        n_tests  = 0;
        loaded   = 1'b0;
        $readmemh("lsu_input.txt", rows);
        // count rows up to the end marker
        while (n_tests < MAX_ROWS && rows[n_tests*COLS] != END_MARK) begin
            n_tests++;
        end
        assert (n_tests > 0 && n_tests < MAX_ROWS) else begin
            $display("input table is missing, empty or has no end row");
            errors++;
        end
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        idle_after_reset();
        if (n_tests < MAX_ROWS) begin
            for (int i = 0; i < n_tests; i++) begin
                run_access(i);
            end
        end
        $display("tests=%0d passed=%0d failed=%0d errors=%0d",
                 n_tests, n_tests - failed, failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // budget of 20 cycles per access plus reset
    initial begin
        wait (loaded);
        repeat (n_tests * CYCLES_PER_TEST + RESET_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish",
                 n_tests * CYCLES_PER_TEST + RESET_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- lsu_input.txt
// columns: op addr wdata exp_data exp_err (hex), op 0-4 LB LBU LH LHU LW, 5-7 SB SH SW
// stores expect zero data; a row with op f ends the table
7 00000020 11223344 00000000 0
4 00000020 00000000 11223344 0
5 00000021 abcdef55 00000000 0
5 00000023 00000037 00000000 0
4 00000020 00000000 37225544 0
5 00000020 000000aa 00000000 0
5 00000022 123456e6 00000000 0
6 00000024 1234beef 00000000 0
6 00000026 00008001 00000000 0
4 00000024 00000000 8001beef 0
0 00000020 00000000 ffffffaa 0
0 00000021 00000000 00000055 0
0 00000022 00000000 ffffffe6 0
0 00000023 00000000 00000037 0
1 00000020 00000000 000000aa 0
1 00000021 00000000 00000055 0
1 00000022 00000000 000000e6 0
1 00000023 00000000 00000037 0
2 00000024 00000000 ffffbeef 0
2 00000026 00000000 ffff8001 0
3 00000024 00000000 0000beef 0
3 00000026 00000000 00008001 0
7 00000400 cafef00d 00000000 1
4 00000400 00000000 00000000 1
4 00000000 00000000 00000000 0
f 00000000 00000000 00000000 0

//--- compile.f
axi_pkg.sv
lsu_pkg.sv
gap_timer.sv
load_align.sv
store_align.sv
axi_sram.sv
lsu_ctrl.sv
lsu_top.sv
tb_lsu.sv

//--- Makefile
TOP = tb_lsu

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

lint:
	verilator --lint-only -Wall --timing --assert --top-module lsu_top \
		axi_pkg.sv lsu_pkg.sv gap_timer.sv load_align.sv store_align.sv \
		axi_sram.sv lsu_ctrl.sv lsu_top.sv

clean:
	rm -rf obj_dir sim.log
